// File: src/ant_pkg.sv
package ant_pkg;

    // Ant table and screen coordinate sizes
    localparam int num_ants     = 4;
    localparam int id_width     = 2;
    localparam int x_width      = 8;
    localparam int y_width      = 7;
    localparam int colour_width = 3;

    localparam logic [colour_width-1:0] ant_colour = 3'b100;

    // Sprite is a square block centred on the ant
    localparam int ant_width  = 3;
    localparam int ant_height = 3;

    // Spawn points, spread out along a diagonal
    localparam int init_x_base = 20;
    localparam int init_x_step = 40;
    localparam int init_y_base = 10;
    localparam int init_y_step = 20;

    typedef enum logic [1:0] {
        mem_read  = 2'd0,
        mem_write = 2'd1,
        mem_draw  = 2'd2
    } opcode_t;

    typedef enum logic {
        field_x = 1'b0,
        field_y = 1'b1
    } field_t;

    // Coordinates wrap, so no edge checks are needed
    typedef enum logic [1:0] {
        dir_left  = 2'd0,
        dir_right = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    typedef struct packed {
        logic [x_width-1:0]      x;
        logic [y_width-1:0]      y;
        logic [colour_width-1:0] colour;
    } pixel_t;

    // A y write value sits in the low bits of value
    typedef struct packed {
        opcode_t             opcode;
        field_t              field;
        logic [id_width-1:0] id;
        logic [x_width-1:0]  value;
        pixel_t              pixel;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        owner_none    = 2'd0,
        owner_drawer  = 2'd1,
        owner_updater = 2'd2
    } owner_t;

    function automatic logic [x_width-1:0] init_x(input int n);
        return x_width'(init_x_base + n * init_x_step);
    endfunction

    function automatic logic [y_width-1:0] init_y(input int n);
        return y_width'(init_y_base + n * init_y_step);
    endfunction

endpackage

// File: src/ant_memory.sv
module ant_memory (
    input  logic                        clock,
    input  logic                        resetn,
    input  logic                        cmd_start,
    input  ant_pkg::mem_cmd_t           cmd,
    output logic                        cmd_done,
    output logic [ant_pkg::x_width-1:0] result,
    output logic                        pixel_valid,
    output ant_pkg::pixel_t             pixel
);
    import ant_pkg::*;

    logic [x_width-1:0] x_mem [num_ants];
    logic [y_width-1:0] y_mem [num_ants];

    // Position table, preset to the spawn points
    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < num_ants; i++) begin
                x_mem[i] <= init_x(i);
                y_mem[i] <= init_y(i);
            end
        end else if (cmd_start && cmd.opcode == mem_write) begin
            if (cmd.field == field_x) begin
                x_mem[cmd.id] <= cmd.value;
            end else begin
                y_mem[cmd.id] <= cmd.value[y_width-1:0];
            end
        end
    end

    // Fixed latency of one cycle for every opcode
    always_ff @(posedge clock) begin
        if (!resetn) begin
            cmd_done    <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            cmd_done    <= cmd_start;
            pixel_valid <= cmd_start && (cmd.opcode == mem_draw);
        end
    end

    // Read data and pixel payload
    always_ff @(posedge clock) begin
        if (cmd_start) begin
            // A write returns the value it replaces
            if (cmd.field == field_x) begin
                result <= x_mem[cmd.id];
            end else begin
                result <= x_width'(y_mem[cmd.id]);
            end
            if (cmd.opcode == mem_draw) begin
                pixel <= cmd.pixel;
            end
        end
    end

endmodule

// File: src/bus_arbiter.sv
module bus_arbiter (
    input  logic                        clock,
    input  logic                        resetn,
    input  logic                        draw_req,
    input  logic                        draw_cmd_start,
    input  ant_pkg::mem_cmd_t           draw_cmd,
    input  logic                        update_req,
    input  logic                        update_cmd_start,
    input  ant_pkg::mem_cmd_t           update_cmd,
    input  logic                        mem_done,
    input  logic [ant_pkg::x_width-1:0] mem_result,
    output logic                        draw_grant,
    output logic                        draw_done,
    output logic                        update_grant,
    output logic                        update_done,
    output logic [ant_pkg::x_width-1:0] result,
    output logic                        mem_cmd_start,
    output ant_pkg::mem_cmd_t           mem_cmd
);
    import ant_pkg::*;

    owner_t owner;

    // Grant only from idle, updater has priority
    always_ff @(posedge clock) begin
        if (!resetn) begin
            owner <= owner_none;
        end else begin
            case (owner)
                owner_none: begin
                    if (update_req) begin
                        owner <= owner_updater;
                    end else if (draw_req) begin
                        owner <= owner_drawer;
                    end
                end
                owner_drawer: begin
                    if (!draw_req) begin
                        owner <= owner_none;
                    end
                end
                owner_updater: begin
                    if (!update_req) begin
                        owner <= owner_none;
                    end
                end
                default: owner <= owner_none;
            endcase
        end
    end

    assign draw_grant   = (owner == owner_drawer);
    assign update_grant = (owner == owner_updater);

    // Strobes from an engine that does not own the bus are dropped
    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd       = '0;
        case (owner)
            owner_drawer: begin
                mem_cmd_start = draw_cmd_start;
                mem_cmd       = draw_cmd;
            end
            owner_updater: begin
                mem_cmd_start = update_cmd_start;
                mem_cmd       = update_cmd;
            end
            default: ;
        endcase
    end

    assign draw_done   = mem_done && draw_grant;
    assign update_done = mem_done && update_grant;
    assign result      = mem_result;

endmodule

// File: src/ant_drawer.sv
module ant_drawer (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    input  logic [ant_pkg::id_width-1:0] id,
    input  logic                         grant,
    input  logic                         done,
    input  logic [ant_pkg::x_width-1:0]  result,
    output logic                         finished,
    output logic                         req,
    output logic                         cmd_start,
    output ant_pkg::mem_cmd_t            cmd
);
    import ant_pkg::*;

    typedef enum logic [2:0] {
        st_standby,
        st_request,
        st_read_x,
        st_read_y,
        st_draw_issue,
        st_draw_wait
    } state_t;

    state_t              state;
    logic [id_width-1:0] ant_id;
    logic [x_width-1:0]  ant_x;
    logic [y_width-1:0]  ant_y;
    logic [1:0]          col;
    logic [1:0]          row;

    // Each command takes a strobe cycle and a done cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= st_standby;
            finished  <= 1'b1;
            req       <= 1'b0;
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            case (state)
                st_standby: begin
                    if (start) begin
                        ant_id   <= id;
                        col      <= '0;
                        row      <= '0;
                        finished <= 1'b0;
                        req      <= 1'b1;
                        state    <= st_request;
                    end
                end
                st_request: begin
                    if (grant) begin
                        cmd_start <= 1'b1;
                        state     <= st_read_x;
                    end
                end
                st_read_x: begin
                    if (done) begin
                        ant_x     <= result;
                        cmd_start <= 1'b1;
                        state     <= st_read_y;
                    end
                end
                st_read_y: begin
                    if (done) begin
                        ant_y     <= result[y_width-1:0];
                        cmd_start <= 1'b1;
                        state     <= st_draw_issue;
                    end
                end
                st_draw_issue: state <= st_draw_wait;
                st_draw_wait: begin
                    if (done) begin
                        // Row-major walk over the block
                        if (col == ant_width - 1) begin
                            col <= '0;
                            if (row == ant_height - 1) begin
                                req      <= 1'b0;
                                finished <= 1'b1;
                                state    <= st_standby;
                            end else begin
                                row       <= row + 2'd1;
                                cmd_start <= 1'b1;
                                state     <= st_draw_issue;
                            end
                        end else begin
                            col       <= col + 2'd1;
                            cmd_start <= 1'b1;
                            state     <= st_draw_issue;
                        end
                    end
                end
                default: state <= st_standby;
            endcase
        end
    end

    // Block's top-left corner is one up and one left of the ant
    always_comb begin
        cmd.id           = ant_id;
        cmd.value        = '0;
        cmd.pixel.x      = ant_x + x_width'(col) - x_width'(1);
        cmd.pixel.y      = ant_y + y_width'(row) - y_width'(1);
        cmd.pixel.colour = ant_colour;
        cmd.opcode       = mem_draw;
        cmd.field        = field_x;
        case (state)
            st_read_x: cmd.opcode = mem_read;
            st_read_y: begin
                cmd.opcode = mem_read;
                cmd.field  = field_y;
            end
            default: ;
        endcase
    end

endmodule

// File: src/ant_updater.sv
module ant_updater (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    input  logic [ant_pkg::id_width-1:0] id,
    input  ant_pkg::dir_t                dir,
    input  logic                         grant,
    input  logic                         done,
    input  logic [ant_pkg::x_width-1:0]  result,
    output logic                         finished,
    output logic                         req,
    output logic                         cmd_start,
    output ant_pkg::mem_cmd_t            cmd
);
    import ant_pkg::*;

    typedef enum logic [2:0] {
        st_standby,
        st_request,
        st_read_x,
        st_read_y,
        st_step,
        st_write_x,
        st_write_y
    } state_t;

    state_t              state;
    logic [id_width-1:0] ant_id;
    dir_t                ant_dir;
    logic [x_width-1:0]  ant_x;
    logic [y_width-1:0]  ant_y;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= st_standby;
            finished  <= 1'b1;
            req       <= 1'b0;
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            case (state)
                st_standby: begin
                    if (start) begin
                        ant_id   <= id;
                        ant_dir  <= dir;
                        finished <= 1'b0;
                        req      <= 1'b1;
                        state    <= st_request;
                    end
                end
                st_request: begin
                    if (grant) begin
                        cmd_start <= 1'b1;
                        state     <= st_read_x;
                    end
                end
                st_read_x: begin
                    if (done) begin
                        ant_x     <= result;
                        cmd_start <= 1'b1;
                        state     <= st_read_y;
                    end
                end
                st_read_y: begin
                    if (done) begin
                        ant_y <= result[y_width-1:0];
                        state <= st_step;
                    end
                end
                st_step: begin
                    // Up is toward row zero
                    case (ant_dir)
                        dir_left:  ant_x <= ant_x - x_width'(1);
                        dir_right: ant_x <= ant_x + x_width'(1);
                        dir_up:    ant_y <= ant_y - y_width'(1);
                        dir_down:  ant_y <= ant_y + y_width'(1);
                        default: ;
                    endcase
                    cmd_start <= 1'b1;
                    state     <= st_write_x;
                end
                st_write_x: begin
                    if (done) begin
                        cmd_start <= 1'b1;
                        state     <= st_write_y;
                    end
                end
                st_write_y: begin
                    if (done) begin
                        req      <= 1'b0;
                        finished <= 1'b1;
                        state    <= st_standby;
                    end
                end
                default: state <= st_standby;
            endcase
        end
    end

    always_comb begin
        cmd.opcode = mem_read;
        cmd.field  = field_x;
        cmd.id     = ant_id;
        cmd.value  = ant_x;
        cmd.pixel  = '0;
        case (state)
            st_read_y: cmd.field = field_y;
            st_write_x: cmd.opcode = mem_write;
            st_write_y: begin
                cmd.opcode = mem_write;
                cmd.field  = field_y;
                cmd.value  = x_width'(ant_y);
            end
            default: ;
        endcase
    end

endmodule

// File: src/ant_engine_top.sv
module ant_engine_top (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         draw_start,
    input  logic [ant_pkg::id_width-1:0] draw_id,
    output logic                         draw_finished,
    input  logic                         update_start,
    input  logic [ant_pkg::id_width-1:0] update_id,
    input  ant_pkg::dir_t                update_dir,
    output logic                         update_finished,
    output logic                         pixel_valid,
    output ant_pkg::pixel_t              pixel
);
    import ant_pkg::*;

    logic               draw_req;
    logic               draw_grant;
    logic               draw_cmd_start;
    logic               draw_done;
    mem_cmd_t           draw_cmd;
    logic               update_req;
    logic               update_grant;
    logic               update_cmd_start;
    logic               update_done;
    mem_cmd_t           update_cmd;
    logic [x_width-1:0] bus_result;
    logic               mem_cmd_start;
    logic               mem_done;
    mem_cmd_t           mem_cmd;
    logic [x_width-1:0] mem_result;

    ant_drawer drawer0 (
        .clock(clock), .resetn(resetn), .start(draw_start), .id(draw_id),
        .grant(draw_grant), .done(draw_done), .result(bus_result),
        .finished(draw_finished), .req(draw_req),
        .cmd_start(draw_cmd_start), .cmd(draw_cmd)
    );

    ant_updater updater0 (
        .clock(clock), .resetn(resetn), .start(update_start), .id(update_id),
        .dir(update_dir), .grant(update_grant), .done(update_done),
        .result(bus_result), .finished(update_finished), .req(update_req),
        .cmd_start(update_cmd_start), .cmd(update_cmd)
    );

    // Both engines share one command bus to the position table
    bus_arbiter arbiter0 (
        .clock(clock), .resetn(resetn),
        .draw_req(draw_req), .draw_cmd_start(draw_cmd_start), .draw_cmd(draw_cmd),
        .update_req(update_req), .update_cmd_start(update_cmd_start),
        .update_cmd(update_cmd), .mem_done(mem_done), .mem_result(mem_result),
        .draw_grant(draw_grant), .draw_done(draw_done),
        .update_grant(update_grant), .update_done(update_done),
        .result(bus_result), .mem_cmd_start(mem_cmd_start), .mem_cmd(mem_cmd)
    );

    ant_memory memory0 (
        .clock(clock), .resetn(resetn), .cmd_start(mem_cmd_start), .cmd(mem_cmd),
        .cmd_done(mem_done), .result(mem_result),
        .pixel_valid(pixel_valid), .pixel(pixel)
    );

endmodule

// File: verif/ant_engine_properties.sv
module ant_engine_properties (
    input logic clock,
    input logic resetn,
    input logic draw_grant,
    input logic update_grant,
    input logic mem_cmd_start,
    input logic mem_done,
    input logic pixel_valid,
    input logic draw_start,
    input logic draw_finished,
    input logic update_start,
    input logic update_finished
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Only one engine may own the bus
    grants_exclusive: assert property (@(posedge clock) disable iff (!resetn)
        !(draw_grant && update_grant))
        else begin
            $error("Both grants are high in the same cycle");
            failures++;
        end

    // Memory latency is fixed at one cycle
    done_follows_start: assert property (@(posedge clock) disable iff (!resetn)
        mem_cmd_start |=> mem_done)
        else begin
            $error("Memory done did not follow a command strobe");
            failures++;
        end

    done_has_start: assert property (@(posedge clock) disable iff (!resetn)
        mem_done |-> $past(mem_cmd_start))
        else begin
            $error("Memory done without a command strobe one cycle earlier");
            failures++;
        end

    pixel_while_drawing: assert property (@(posedge clock) disable iff (!resetn)
        pixel_valid |-> draw_grant)
        else begin
            $error("Pixel output while the drawer does not own the bus");
            failures++;
        end

    draw_fall_needs_start: assert property (@(posedge clock) disable iff (!resetn)
        $fell(draw_finished) |-> $past(draw_start))
        else begin
            $error("Draw finished fell without a draw start");
            failures++;
        end

    update_fall_needs_start: assert property (@(posedge clock) disable iff (!resetn)
        $fell(update_finished) |-> $past(update_start))
        else begin
            $error("Update finished fell without an update start");
            failures++;
        end

endmodule

bind ant_engine_top ant_engine_properties props0 (
    .clock(clock), .resetn(resetn),
    .draw_grant(draw_grant), .update_grant(update_grant),
    .mem_cmd_start(mem_cmd_start), .mem_done(mem_done), .pixel_valid(pixel_valid),
    .draw_start(draw_start), .draw_finished(draw_finished),
    .update_start(update_start), .update_finished(update_finished)
);

// File: verif/tb_ant_engine.sv
module tb_ant_engine;
    timeunit 1ns;
    timeprecision 100ps;
    import ant_pkg::*;

    // Upper bound on operations for the watchdog budget
    localparam int num_random     = 20;
    localparam int max_wrap_moves = 40;
    localparam int num_ops        = 4 + 8 + 2 + num_random + max_wrap_moves + 2;
    localparam int op_limit       = 120;

    logic                clock;
    logic                resetn;
    logic                draw_start;
    logic [id_width-1:0] draw_id;
    logic                update_start;
    logic [id_width-1:0] update_id;
    dir_t                update_dir;
    logic                draw_finished;
    logic                update_finished;
    logic                pixel_valid;
    pixel_t              pixel;

    logic [x_width-1:0]  model_x [num_ants];
    logic [y_width-1:0]  model_y [num_ants];
    pixel_t              expected_q [$];
    logic [7:0]          lfsr;
    int                  errors;
    int                  pixels_checked;
    int                  ops_done;
    logic                wrapped;

    ant_engine_top dut0 (
        .clock(clock), .resetn(resetn),
        .draw_start(draw_start), .draw_id(draw_id), .draw_finished(draw_finished),
        .update_start(update_start), .update_id(update_id), .update_dir(update_dir),
        .update_finished(update_finished), .pixel_valid(pixel_valid), .pixel(pixel)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[6:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 8'hb8) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Up moves toward row zero and coordinates wrap at their width
    task automatic step_model(input logic [id_width-1:0] id, input dir_t dir);
        case (dir)
            dir_left:  model_x[id] = model_x[id] - 8'd1;
            dir_right: model_x[id] = model_x[id] + 8'd1;
            dir_up:    model_y[id] = model_y[id] - 7'd1;
            default:   model_y[id] = model_y[id] + 7'd1;
        endcase
    endtask

    // Nine pixels in row-major order around the ant
    task automatic push_block(input logic [id_width-1:0] id);
        pixel_t p;
        for (int row = 0; row < ant_height; row++) begin
            for (int col = 0; col < ant_width; col++) begin
                p.x      = model_x[id] - 8'd1 + 8'(col);
                p.y      = model_y[id] - 7'd1 + 7'(row);
                p.colour = ant_colour;
                expected_q.push_back(p);
            end
        end
    endtask

    task automatic wait_finished();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!(draw_finished && update_finished) && cycles < op_limit) begin
            @(negedge clock);
            cycles++;
        end
        assert (draw_finished && update_finished) else begin
            $display("Operation did not finish within %0d cycles", op_limit);
            errors++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Draw ended with %0d pixels missing", expected_q.size());
            errors++;
            expected_q.delete();
        end
    endtask

    task automatic do_draw(input logic [id_width-1:0] id);
        push_block(id);
        @(posedge clock);
        draw_start <= 1'b1;
        draw_id    <= id;
        @(posedge clock);
        draw_start <= 1'b0;
        wait_finished();
        ops_done++;
    endtask

    task automatic do_update(input logic [id_width-1:0] id, input dir_t dir);
        step_model(id, dir);
        @(posedge clock);
        update_start <= 1'b1;
        update_id    <= id;
        update_dir   <= dir;
        @(posedge clock);
        update_start <= 1'b0;
        wait_finished();
        ops_done++;
    endtask

    // Updater wins the tie, so the draw sees the moved ant
    task automatic do_both(input logic [id_width-1:0] id, input dir_t dir);
        step_model(id, dir);
        push_block(id);
        @(posedge clock);
        draw_start   <= 1'b1;
        draw_id      <= id;
        update_start <= 1'b1;
        update_id    <= id;
        update_dir   <= dir;
        @(posedge clock);
        draw_start   <= 1'b0;
        update_start <= 1'b0;
        wait_finished();
        ops_done += 2;
    endtask

    always @(negedge clock) begin
        if (resetn && pixel_valid) begin
            assert (expected_q.size() > 0) else begin
                $display("Pixel appeared while no draw was expected");
                errors++;
            end
            if (expected_q.size() > 0) begin
                assert (pixel.x == expected_q[0].x) else begin
                    $display("Fail pixel.x expected %h got %h", expected_q[0].x, pixel.x);
                    errors++;
                end
                assert (pixel.y == expected_q[0].y) else begin
                    $display("Fail pixel.y expected %h got %h", expected_q[0].y, pixel.y);
                    errors++;
                end
                assert (pixel.colour == expected_q[0].colour) else begin
                    $display("Fail pixel.colour expected %h got %h",
                             expected_q[0].colour, pixel.colour);
                    errors++;
                end
                void'(expected_q.pop_front());
                pixels_checked++;
            end
        end
    end

    initial begin
        repeat (num_ops * 60 + 200) @(posedge clock);
        $display("Timeout: the tests did not complete within the cycle budget");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        resetn         = 1'b0;
        draw_start     = 1'b0;
        draw_id        = '0;
        update_start   = 1'b0;
        update_id      = '0;
        update_dir     = dir_left;
        lfsr           = 8'd24;
        errors         = 0;
        pixels_checked = 0;
        ops_done       = 0;
        wrapped        = 1'b0;
        for (int n = 0; n < num_ants; n++) begin
            model_x[n] = 8'(init_x_base + n * init_x_step);
            model_y[n] = 7'(init_y_base + n * init_y_step);
        end
        repeat (3) @(posedge clock);
        resetn <= 1'b1;
        @(negedge clock);
        assert (draw_finished && update_finished && !pixel_valid) else begin
            $display("Outputs after reset are not idle");
            errors++;
        end

        for (int n = 0; n < num_ants; n++) begin
            do_draw(n);
        end
        // One ant per direction
        for (int d = 0; d < 4; d++) begin
            do_update(d, dir_t'(d));
            do_draw(d);
        end
        do_both(random_bits(2), dir_t'(random_bits(2)));

        for (int i = 0; i < num_random; i++) begin
            if (random_bits(1)) begin
                do_update(random_bits(2), dir_t'(random_bits(2)));
            end else begin
                do_draw(random_bits(2));
            end
        end

        // Walk ant 0 up until its row wraps past zero
        for (int i = 0; i < max_wrap_moves && !wrapped; i++) begin
            do_update(0, dir_up);
            if (model_y[0] == 7'd0) begin
                do_draw(0);
            end
            if (model_y[0] == 7'h7f) begin
                do_draw(0);
                wrapped = 1'b1;
            end
        end
        assert (wrapped) else begin
            $display("The y coordinate of ant 0 never wrapped past zero");
            errors++;
        end

        $display("Operations %0d, pixels checked %0d, errors %0d, assertion failures %0d",
                 ops_done, pixels_checked, errors, dut0.props0.failures);
        if (errors == 0 && dut0.props0.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
src/ant_pkg.sv
src/ant_memory.sv
src/bus_arbiter.sv
src/ant_drawer.sv
src/ant_updater.sv
src/ant_engine_top.sv
verif/ant_engine_properties.sv
verif/tb_ant_engine.sv
